/* test/mcseq_trace.txt */
// credit-return delays in cycles: count, then the delay values
8
0 2 1 5 0 3 7 1
// instruction count, then per instruction in issue order:
// steps dst src0 src1 csig_step0 csig_step1 csig_step2 (fields after offsets, mod 128)
6
3 0a 01 02 00124 00284 04306   // FP2_MUL at 1
2 0b 0a 00 04108 00025 00000   // FP2_SQR at 2
3 04 04 43 00124 00284 04306   // FP2_MUL at 9, offsets 32 32 64
2 25 26 47 00024 00084 00000   // ACC_SUB at 10, offsets 32 32 64
3 0c 0b 00 00128 00265 04000   // FP2_SQR_XI at 6, after RET
2 0d 0c 0a 00024 00084 00000   // ACC_SUB at 7

/* flist.f */
+incdir+hw
hw/mcseq_pkg.sv
hw/program_rom.sv
hw/program_counter.sv
hw/mop_expander.sv
hw/mop_issue.sv
hw/mcseq_top.sv
test/tb_mcseq.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_mcseq with Verilator, run it into sim.log and check it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f flist.f \
		--top-module tb_mcseq -Mdir obj_dir
	./obj_dir/Vtb_mcseq 2>&1 | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/tb_mcseq.sv */
`timescale 1ns/1ps
`include "mcseq_macros.svh"

module tb_mcseq;

    localparam int TRACE_WORDS  = 64;
    localparam int WAIT_LIMIT   = 2000;    // cycles per wait
    localparam int DELAY_PROMPT = 0;
    localparam int DELAY_TRACE  = 1;
    localparam int DELAY_RANDOM = 2;

    logic                     clk;
    logic                     rstn;
    logic                     run;
    logic                     credit_ret;
    logic                     busy;
    logic                     mop_valid;
    mcseq_pkg::csig_t         mop_csig;
    logic [`MCSEQ_ADDR_W-1:0] mop_dst;
    logic [`MCSEQ_ADDR_W-1:0] mop_src0;
    logic [`MCSEQ_ADDR_W-1:0] mop_src1;

    logic [31:0] trace_mem [0:TRACE_WORDS-1];

    mcseq_pkg::csig_t         exp_csig[$];   // expected stream
    logic [`MCSEQ_ADDR_W-1:0] exp_dst[$];
    logic [`MCSEQ_ADDR_W-1:0] exp_src0[$];
    logic [`MCSEQ_ADDR_W-1:0] exp_src1[$];
    mcseq_pkg::csig_t         rx_csig[$];    // what the datapath saw
    logic [`MCSEQ_ADDR_W-1:0] rx_dst[$];
    logic [`MCSEQ_ADDR_W-1:0] rx_src0[$];
    logic [`MCSEQ_ADDR_W-1:0] rx_src1[$];

    int unsigned due_q[$];      // cycle at which each credit goes back
    int unsigned cycle;
    int unsigned delay_idx;
    int          delay_mode;
    logic        hold_credits;
    int          value_errors;
    int          other_errors;

    mcseq_top i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .run        (run),
        .credit_ret (credit_ret),
        .busy       (busy),
        .mop_valid  (mop_valid),
        .mop_csig   (mop_csig),
        .mop_dst    (mop_dst),
        .mop_src0   (mop_src0),
        .mop_src1   (mop_src1)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // datapath model
    //////////////////////////////
    always @(negedge clk) begin
        int unsigned d;
        cycle = cycle + 1;
        if (mop_valid === 1'b1) begin
            rx_csig.push_back(mop_csig);
            rx_dst.push_back(mop_dst);
            rx_src0.push_back(mop_src0);
            rx_src1.push_back(mop_src1);
            case (delay_mode)
                DELAY_TRACE: begin
                    d = trace_mem[1 + delay_idx % trace_mem[0]];
                    delay_idx = delay_idx + 1;
                end
                DELAY_RANDOM: d = $urandom % 6;
                default: d = 0;
            endcase
            due_q.push_back(cycle + d);
        end
        // one credit back per cycle at most
        if (!hold_credits && due_q.size() > 0 && due_q[0] <= cycle) begin
            credit_ret = 1'b1;
            void'(due_q.pop_front());
        end else begin
            credit_ret = 1'b0;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////
    task automatic check_csig(input string name, input mcseq_pkg::csig_t exp_v,
                              input mcseq_pkg::csig_t act_v);
        if (act_v !== exp_v) begin
            value_errors++;
            $display("FAILED %s expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_addr(input string name, input logic [`MCSEQ_ADDR_W-1:0] exp_v,
                              input logic [`MCSEQ_ADDR_W-1:0] act_v);
        if (act_v !== exp_v) begin
            value_errors++;
            $display("FAILED %s expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            value_errors++;
            $display("FAILED %s expected %b actual %b", name, exp_v, act_v);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        other_errors++;
        $display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
        finish_run();
    endtask

    // per instruction, every thread runs the full step list
    task automatic build_expected();
        int base;
        int n_instr;
        int n_steps;
        base = trace_mem[0] + 1;   // skip the delay table
        n_instr = trace_mem[base];
        base++;
        for (int i = 0; i < n_instr; i++) begin
            n_steps = trace_mem[base];
            for (int t = 0; t < `MCSEQ_THREADS; t++) begin
                for (int s = 0; s < n_steps; s++) begin
                    exp_csig.push_back(mcseq_pkg::csig_t'(trace_mem[base + 4 + s][16:0]));
                    exp_dst.push_back({`MCSEQ_THREAD_W'(t), trace_mem[base + 1][6:0]});
                    exp_src0.push_back({`MCSEQ_THREAD_W'(t), trace_mem[base + 2][6:0]});
                    exp_src1.push_back({`MCSEQ_THREAD_W'(t), trace_mem[base + 3][6:0]});
                end
            end
            base += 7;
        end
    endtask

    task automatic wait_busy(input logic level, input string what);
        int n;
        n = 0;
        while (busy !== level) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) timeout_abort(what);
        end
    endtask

    task automatic wait_rx_count(input int count, input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) timeout_abort(what);
        end while (rx_csig.size() < count);
    endtask

    task automatic wait_credits_home(input string name);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) timeout_abort({name, ": all credits returned"});
        end while (due_q.size() > 0);
    endtask

    task automatic start_run(input string name);
        rx_csig.delete();
        rx_dst.delete();
        rx_src0.delete();
        rx_src1.delete();
        @(negedge clk);
        run = 1'b1;
        @(negedge clk);
        run = 1'b0;
        check_flag({name, " busy after run"}, 1'b1, busy);
    endtask

    task automatic compare_stream(input string name);
        if (rx_csig.size() != exp_csig.size()) begin
            other_errors++;
            $display("%s: received %0d micro-ops where %0d were expected",
                     name, rx_csig.size(), exp_csig.size());
        end
        for (int i = 0; i < exp_csig.size() && i < rx_csig.size(); i++) begin
            check_csig($sformatf("%s mop %0d csig", name, i), exp_csig[i], rx_csig[i]);
            check_addr($sformatf("%s mop %0d dst", name, i), exp_dst[i], rx_dst[i]);
            check_addr($sformatf("%s mop %0d src0", name, i), exp_src0[i], rx_src0[i]);
            check_addr($sformatf("%s mop %0d src1", name, i), exp_src1[i], rx_src1[i]);
        end
    endtask

    task automatic finish_pass(input string name);
        wait_busy(1'b0, {name, ": busy to fall"});
        @(posedge clk);
        if (rx_csig.size() != exp_csig.size()) begin
            other_errors++;
            $display("%s: busy fell with %0d of %0d micro-ops issued",
                     name, rx_csig.size(), exp_csig.size());
        end
        repeat (10) begin
            @(negedge clk);
            check_flag({name, " quiet after halt"}, 1'b0, mop_valid);
        end
        wait_credits_home(name);
        compare_stream(name);
    endtask

    task automatic run_pass(input string name, input int mode);
        wait_credits_home(name);
        delay_mode = mode;
        start_run(name);
        finish_pass(name);
    endtask

    // datapath keeps every credit until the stall is seen
    task automatic withheld_pass();
        wait_credits_home("withheld");
        delay_mode = DELAY_PROMPT;
        hold_credits = 1'b1;
        start_run("withheld");
        wait_rx_count(`MCSEQ_CREDITS, "withheld: first micro-ops");
        repeat (20) begin
            @(negedge clk);
            check_flag("withheld mop_valid", 1'b0, mop_valid);
            check_flag("withheld busy", 1'b1, busy);
        end
        @(posedge clk);
        if (rx_csig.size() != `MCSEQ_CREDITS) begin
            other_errors++;
            $display("withheld: %0d micro-ops issued without credit return, expected %0d",
                     rx_csig.size(), `MCSEQ_CREDITS);
        end
        hold_credits = 1'b0;
        finish_pass("withheld");
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        void'($urandom(37354));
        rstn = 1'b0;
        run = 1'b0;
        credit_ret = 1'b0;
        cycle = 0;
        delay_idx = 0;
        delay_mode = DELAY_PROMPT;
        hold_credits = 1'b0;
        value_errors = 0;
        other_errors = 0;
        $readmemh("test/mcseq_trace.txt", trace_mem);
        if ($isunknown(trace_mem[0])) begin
            other_errors++;
            $display("trace file test/mcseq_trace.txt could not be read");
            finish_run();
        end else begin
            build_expected();

            repeat (8) @(negedge clk);
            rstn = 1'b1;
            repeat (20) begin
                @(negedge clk);
                check_flag("idle busy", 1'b0, busy);
                check_flag("idle mop_valid", 1'b0, mop_valid);
            end

            run_pass("prompt", DELAY_PROMPT);
            withheld_pass();
            run_pass("trace delays", DELAY_TRACE);
            run_pass("random delays", DELAY_RANDOM);
            finish_run();
        end
    end

endmodule

/* hw/mcseq_top.sv */
`timescale 1ns/1ps
`include "mcseq_macros.svh"

module mcseq_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     run,
    input  logic                     credit_ret,
    output logic                     busy,
    output logic                     mop_valid,
    output mcseq_pkg::csig_t         mop_csig,
    output logic [`MCSEQ_ADDR_W-1:0] mop_dst,
    output logic [`MCSEQ_ADDR_W-1:0] mop_src0,
    output logic [`MCSEQ_ADDR_W-1:0] mop_src1
);

    logic [`MCSEQ_PC_W-1:0]     rom_addr;
    mcseq_pkg::instr_t          instr;
    logic                       instr_valid;
    logic                       instr_done;
    logic [`MCSEQ_OFS_W-1:0]    ofs_dst;
    logic [`MCSEQ_OFS_W-1:0]    ofs_src0;
    logic [`MCSEQ_OFS_W-1:0]    ofs_src1;
    logic                       step_valid;
    logic                       step_accept;
    mcseq_pkg::csig_t           step_csig;
    logic [`MCSEQ_THREAD_W-1:0] step_thread;
    logic [`MCSEQ_OFS_W-1:0]    step_dst;
    logic [`MCSEQ_OFS_W-1:0]    step_src0;
    logic [`MCSEQ_OFS_W-1:0]    step_src1;

    program_rom i_rom (
        .clk      (clk),
        .rom_addr (rom_addr),
        .instr    (instr)
    );

    program_counter i_pc (
        .clk         (clk),
        .rstn        (rstn),
        .run         (run),
        .instr       (instr),
        .instr_done  (instr_done),
        .rom_addr    (rom_addr),
        .instr_valid (instr_valid),
        .busy        (busy),
        .ofs_dst     (ofs_dst),
        .ofs_src0    (ofs_src0),
        .ofs_src1    (ofs_src1)
    );

    mop_expander i_exp (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .step_accept (step_accept),
        .instr_done  (instr_done),
        .step_valid  (step_valid),
        .step_csig   (step_csig),
        .step_thread (step_thread),
        .step_dst    (step_dst),
        .step_src0   (step_src0),
        .step_src1   (step_src1)
    );

    mop_issue i_issue (
        .clk         (clk),
        .rstn        (rstn),
        .step_valid  (step_valid),
        .step_csig   (step_csig),
        .step_thread (step_thread),
        .step_dst    (step_dst),
        .step_src0   (step_src0),
        .step_src1   (step_src1),
        .ofs_dst     (ofs_dst),
        .ofs_src0    (ofs_src0),
        .ofs_src1    (ofs_src1),
        .credit_ret  (credit_ret),
        .step_accept (step_accept),
        .mop_valid   (mop_valid),
        .mop_csig    (mop_csig),
        .mop_dst     (mop_dst),
        .mop_src0    (mop_src0),
        .mop_src1    (mop_src1)
    );

endmodule

/* hw/mop_issue.sv */
`timescale 1ns/1ps
`include "mcseq_macros.svh"

module mop_issue (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        step_valid,
    input  mcseq_pkg::csig_t            step_csig,
    input  logic [`MCSEQ_THREAD_W-1:0]  step_thread,
    input  logic [`MCSEQ_OFS_W-1:0]     step_dst,
    input  logic [`MCSEQ_OFS_W-1:0]     step_src0,
    input  logic [`MCSEQ_OFS_W-1:0]     step_src1,
    input  logic [`MCSEQ_OFS_W-1:0]     ofs_dst,
    input  logic [`MCSEQ_OFS_W-1:0]     ofs_src0,
    input  logic [`MCSEQ_OFS_W-1:0]     ofs_src1,
    input  logic                        credit_ret,
    output logic                        step_accept,
    output logic                        mop_valid,
    output mcseq_pkg::csig_t            mop_csig,
    output logic [`MCSEQ_ADDR_W-1:0]    mop_dst,
    output logic [`MCSEQ_ADDR_W-1:0]    mop_src0,
    output logic [`MCSEQ_ADDR_W-1:0]    mop_src1
);

    logic [`MCSEQ_CREDIT_W-1:0] credit_cnt;
    logic [`MCSEQ_CREDIT_W-1:0] in_flight;  // output side, issued and not yet returned
    logic [`MCSEQ_OFS_W-1:0]    dst_sum;    // mod 128 sums
    logic [`MCSEQ_OFS_W-1:0]    src0_sum;
    logic [`MCSEQ_OFS_W-1:0]    src1_sum;

    assign step_accept = step_valid && (credit_cnt != '0);

    assign dst_sum  = step_dst + ofs_dst;
    assign src0_sum = step_src0 + ofs_src0;
    assign src1_sum = step_src1 + ofs_src1;

    ////////////////////////////////
    // credits
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            credit_cnt <= `MCSEQ_CREDIT_W'(`MCSEQ_CREDITS);
        end else begin
            case ({step_accept, credit_ret})
                2'b10:   credit_cnt <= credit_cnt - `MCSEQ_CREDIT_W'(1);
                2'b01:   credit_cnt <= credit_cnt + `MCSEQ_CREDIT_W'(1);
                default: credit_cnt <= credit_cnt; // none, or spend and return together
            endcase
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            mop_valid <= 1'b0;
        end else begin
            mop_valid <= step_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (step_accept) begin
            mop_csig <= step_csig;
            mop_dst  <= {step_thread, dst_sum};   // thread in the upper bits
            mop_src0 <= {step_thread, src0_sum};
            mop_src1 <= {step_thread, src1_sum};
        end
    end

    // counted from mop_valid and credit_ret only
    always_ff @(posedge clk) begin
        if (!rstn) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + `MCSEQ_CREDIT_W'(mop_valid)
                                   - `MCSEQ_CREDIT_W'(credit_ret);
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (!rstn)
        credit_cnt <= `MCSEQ_CREDIT_W'(`MCSEQ_CREDITS));

    // datapath must still have room for each micro-op it receives
    a_valid_has_credit: assert property (@(posedge clk) disable iff (!rstn)
        mop_valid |-> in_flight < `MCSEQ_CREDIT_W'(`MCSEQ_CREDITS));

endmodule

/* hw/mop_expander.sv */
`timescale 1ns/1ps
`include "mcseq_macros.svh"

module mop_expander (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        instr_valid,
    input  mcseq_pkg::instr_t           instr,
    input  logic                        step_accept,
    output logic                        instr_done,
    output logic                        step_valid,
    output mcseq_pkg::csig_t            step_csig,
    output logic [`MCSEQ_THREAD_W-1:0]  step_thread,
    output logic [`MCSEQ_OFS_W-1:0]     step_dst,
    output logic [`MCSEQ_OFS_W-1:0]     step_src0,
    output logic [`MCSEQ_OFS_W-1:0]     step_src1
);

    logic [1:0]                 step_cnt;
    logic [1:0]                 n_steps;
    logic [`MCSEQ_THREAD_W-1:0] thread_cnt;
    logic                       last_step;
    logic                       last_thread;

    ////////////////////////////////
    // step tables
    ////////////////////////////////
    // fields: inve_pos_pom3_pom2_pom1_cm_pm
    function automatic mcseq_pkg::csig_t step_table(input mcseq_pkg::arith_op_e op,
                                                    input logic [1:0] step);
        mcseq_pkg::csig_t c;
        c = mcseq_pkg::csig_nop;
        case (op)
            mcseq_pkg::FP2_MUL: begin
                case (step)
                    2'd0:    c = 17'b0_00_000_001_001_001_00;
                    2'd1:    c = 17'b0_00_000_010_100_001_00;
                    2'd2:    c = 17'b0_01_000_011_000_001_10;
                    default: c = mcseq_pkg::csig_nop;
                endcase
            end
            mcseq_pkg::FP2_SQR: begin
                case (step)
                    2'd0:    c = 17'b0_01_000_001_000_010_00;
                    2'd1:    c = 17'b0_00_000_000_001_001_01;
                    default: c = mcseq_pkg::csig_nop;
                endcase
            end
            mcseq_pkg::FP2_SQR_XI: begin
                case (step)
                    2'd0:    c = 17'b0_00_000_001_001_010_00;
                    2'd1:    c = 17'b0_00_000_010_011_001_01;
                    2'd2:    c = 17'b0_01_000_000_000_000_00; // final add, no mult
                    default: c = mcseq_pkg::csig_nop;
                endcase
            end
            mcseq_pkg::ACC_SUB: begin
                case (step)
                    2'd0:    c = 17'b0_00_000_000_001_001_00;
                    2'd1:    c = 17'b0_00_000_000_100_001_00;
                    default: c = mcseq_pkg::csig_nop;
                endcase
            end
            default: c = mcseq_pkg::csig_nop;
        endcase
        return c;
    endfunction

    assign n_steps = (instr.arith_op == mcseq_pkg::FP2_MUL ||
                      instr.arith_op == mcseq_pkg::FP2_SQR_XI) ? 2'd3 : 2'd2;

    assign last_step   = (step_cnt == n_steps - 2'd1);
    assign last_thread = (thread_cnt == `MCSEQ_THREAD_W'(`MCSEQ_THREADS - 1));
    assign instr_done  = step_accept && last_step && last_thread;

    assign step_valid  = instr_valid;
    assign step_csig   = step_table(instr.arith_op, step_cnt);
    assign step_thread = thread_cnt;
    assign step_dst    = instr.dst;   // raw fields, offsets added at issue
    assign step_src0   = instr.src0;
    assign step_src1   = instr.src1;

    ////////////////////////////////
    // step / thread counters
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            step_cnt   <= '0;
            thread_cnt <= '0;
        end else if (step_accept) begin            // hold on back-pressure
            if (last_step) begin
                step_cnt   <= '0;
                thread_cnt <= thread_cnt + `MCSEQ_THREAD_W'(1); // wraps to 0 at done
            end else begin
                step_cnt <= step_cnt + 2'd1;
            end
        end
    end

    a_step_in_range: assert property (@(posedge clk) disable iff (!rstn)
        instr_valid |-> (step_cnt < n_steps));

endmodule

/* hw/program_counter.sv */
`timescale 1ns/1ps
`include "mcseq_macros.svh"

module program_counter (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    run,
    input  mcseq_pkg::instr_t       instr,
    input  logic                    instr_done,
    output logic [`MCSEQ_PC_W-1:0]  rom_addr,
    output logic                    instr_valid,
    output logic                    busy,
    output logic [`MCSEQ_OFS_W-1:0] ofs_dst,
    output logic [`MCSEQ_OFS_W-1:0] ofs_src0,
    output logic [`MCSEQ_OFS_W-1:0] ofs_src1
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,      // rom_addr presented
        EXEC,       // instr from ROM is valid
        WAIT_DONE   // arithmetic instr held for the expander
    } pc_state_e;

    pc_state_e              state;
    logic [`MCSEQ_PC_W-1:0] pc;
    logic [`MCSEQ_PC_W-1:0] ret_addr;   // single-level call stack

    assign rom_addr    = pc;            // held steady so the ROM word stays put
    assign instr_valid = (state == WAIT_DONE);
    assign busy        = (state != IDLE);

    ////////////////////////////////
    // fetch / branch
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= IDLE;
            pc       <= '0;
            ret_addr <= '0;
            ofs_dst  <= '0;
            ofs_src0 <= '0;
            ofs_src1 <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (run) begin
                        pc    <= `MCSEQ_PC_W'(`MCSEQ_FIRST_PC);
                        state <= FETCH;
                    end
                end
                FETCH: state <= EXEC;
                EXEC: begin
                    if (!instr.is_ctrl) begin
                        state <= WAIT_DONE;
                    end else begin
                        state <= FETCH;
                        case (instr.ctrl_op)
                            mcseq_pkg::JMP: pc <= instr.target;
                            mcseq_pkg::CALL: begin
                                pc       <= instr.target;
                                ret_addr <= pc + `MCSEQ_PC_W'(1);
                                ofs_dst  <= instr.dst;      // offsets for the callee
                                ofs_src0 <= instr.src0;
                                ofs_src1 <= instr.src1;
                            end
                            mcseq_pkg::RET: begin
                                pc       <= ret_addr;
                                ofs_dst  <= '0;
                                ofs_src0 <= '0;
                                ofs_src1 <= '0;
                            end
                            mcseq_pkg::HALT: begin
                                pc    <= '0;
                                state <= IDLE;
                            end
                        endcase
                    end
                end
                WAIT_DONE: begin
                    if (instr_done) begin
                        pc    <= pc + `MCSEQ_PC_W'(1);
                        state <= FETCH;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // expander may only finish an instruction it was handed
    a_done_in_valid: assert property (@(posedge clk) disable iff (!rstn)
        instr_done |-> instr_valid);

endmodule

/* hw/program_rom.sv */
`timescale 1ns/1ps
`include "mcseq_macros.svh"

module program_rom (
    input  logic                    clk,
    input  logic [`MCSEQ_PC_W-1:0]  rom_addr,
    output mcseq_pkg::instr_t       instr
);

    function automatic mcseq_pkg::instr_t ctrl_word(input mcseq_pkg::ctrl_op_e op,
                                                    input logic [`MCSEQ_PC_W-1:0] target,
                                                    input logic [`MCSEQ_OFS_W-1:0] d,
                                                    input logic [`MCSEQ_OFS_W-1:0] s0,
                                                    input logic [`MCSEQ_OFS_W-1:0] s1);
        mcseq_pkg::instr_t w;
        w = '0;
        w.is_ctrl = 1'b1;
        w.ctrl_op = op;
        w.target = target;
        w.dst = d;
        w.src0 = s0;
        w.src1 = s1;
        return w;
    endfunction

    function automatic mcseq_pkg::instr_t arith_word(input mcseq_pkg::arith_op_e op,
                                                     input logic [`MCSEQ_OFS_W-1:0] d,
                                                     input logic [`MCSEQ_OFS_W-1:0] s0,
                                                     input logic [`MCSEQ_OFS_W-1:0] s1);
        mcseq_pkg::instr_t w;
        w = '0;
        w.arith_op = op;
        w.dst = d;
        w.src0 = s0;
        w.src1 = s1;
        return w;
    endfunction

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        case (rom_addr)
            8'd1:    instr <= arith_word(mcseq_pkg::FP2_MUL, 7'd10, 7'd1, 7'd2);
            8'd2:    instr <= arith_word(mcseq_pkg::FP2_SQR, 7'd11, 7'd10, 7'd0);
            8'd3:    instr <= ctrl_word(mcseq_pkg::JMP, 8'd5, 7'd0, 7'd0, 7'd0);
            8'd4:    instr <= arith_word(mcseq_pkg::ACC_SUB, 7'd127, 7'd127, 7'd127); // skipped
            8'd5:    instr <= ctrl_word(mcseq_pkg::CALL, 8'd9, 7'd32, 7'd32, 7'd64);
            8'd6:    instr <= arith_word(mcseq_pkg::FP2_SQR_XI, 7'd12, 7'd11, 7'd0);
            8'd7:    instr <= arith_word(mcseq_pkg::ACC_SUB, 7'd13, 7'd12, 7'd10);
            // subroutine, runs with the CALL offsets
            8'd9:    instr <= arith_word(mcseq_pkg::FP2_MUL, 7'd100, 7'd100, 7'd3); // dst wraps
            8'd10:   instr <= arith_word(mcseq_pkg::ACC_SUB, 7'd5, 7'd6, 7'd7);
            8'd11:   instr <= ctrl_word(mcseq_pkg::RET, 8'd0, 7'd0, 7'd0, 7'd0);
            default: instr <= ctrl_word(mcseq_pkg::HALT, 8'd0, 7'd0, 7'd0, 7'd0); // 0, 8
        endcase
    end

endmodule

/* hw/mcseq_pkg.sv */
`include "mcseq_macros.svh"

package mcseq_pkg;

    // control instructions
    typedef enum logic [1:0] {
        JMP,
        CALL,
        RET,
        HALT
    } ctrl_op_e;

    // arithmetic instructions, each expands into a step table
    typedef enum logic [1:0] {
        FP2_MUL,
        FP2_SQR,
        FP2_SQR_XI,
        ACC_SUB
    } arith_op_e;

    typedef struct packed {
        logic                     is_ctrl;   // 1: ctrl_op valid, 0: arith_op valid
        ctrl_op_e                 ctrl_op;
        arith_op_e                arith_op;
        logic [`MCSEQ_PC_W-1:0]   target;    // JMP / CALL destination
        logic [`MCSEQ_OFS_W-1:0]  dst;       // CALL: offsets to capture
        logic [`MCSEQ_OFS_W-1:0]  src0;
        logic [`MCSEQ_OFS_W-1:0]  src1;
    } instr_t;

    // datapath control word
    typedef struct packed {
        logic       inve;
        logic [1:0] pos;
        logic [2:0] pom3;
        logic [2:0] pom2;
        logic [2:0] pom1;
        logic [2:0] cm;
        logic [1:0] pm;
    } csig_t;

    localparam csig_t csig_nop = '0;

endpackage

/* hw/mcseq_macros.svh */
`ifndef MCSEQ_MACROS_SVH
`define MCSEQ_MACROS_SVH

////////////////////////////////
// program store
////////////////////////////////
`define MCSEQ_PC_W      8   // macro-program address width
`define MCSEQ_FIRST_PC  1   // run entry point, address 0 is HALT

////////////////////////////////
// thread interleave
////////////////////////////////
`define MCSEQ_THREADS   4
`define MCSEQ_THREAD_W  2

// operand addressing
`define MCSEQ_OFS_W     7   // per-thread field inside the register file
`define MCSEQ_ADDR_W    9   // thread number on top of the field

////////////////////////////////
// datapath credits
////////////////////////////////
`define MCSEQ_CREDITS   4
`define MCSEQ_CREDIT_W  3

`endif
